//--- logic/soc_bus_pkg.sv
// Bus widths, memory map and register offsets for the demo SoC peripherals
// Referenced by scoped name from every RTL file of the design
package soc_bus_pkg;

  localparam int BusDataWidth   = 32;                // Data and address
  localparam int BusBeWidth     = BusDataWidth / 8;  // One enable per byte
  localparam int RegOffsetWidth = 8;                 // Low address bits seen by peripherals

  // Memory map, each window given as base and mask
  localparam logic [BusDataWidth-1:0] RamStart   = 32'h0010_0000;
  localparam logic [BusDataWidth-1:0] RamMask    = 32'hFFFF_0000;  // 64 KiB

  localparam logic [BusDataWidth-1:0] GpioStart  = 32'h8000_0000;
  localparam logic [BusDataWidth-1:0] GpioMask   = 32'hFFFF_F000;  // 4 KiB

  localparam logic [BusDataWidth-1:0] TimerStart = 32'h8000_2000;
  localparam logic [BusDataWidth-1:0] TimerMask  = 32'hFFFF_F000;  // 4 KiB

  localparam logic [BusDataWidth-1:0] PwmStart   = 32'h8000_3000;
  localparam logic [BusDataWidth-1:0] PwmMask    = 32'hFFFF_F000;  // 4 KiB

  // GPIO registers
  localparam logic [RegOffsetWidth-1:0] GpioOutOffset = 8'h00;
  localparam logic [RegOffsetWidth-1:0] GpioInOffset  = 8'h04;

  // Timer registers, 64-bit values split in halves
  localparam logic [RegOffsetWidth-1:0] TimerTimeLoOffset = 8'h00;
  localparam logic [RegOffsetWidth-1:0] TimerTimeHiOffset = 8'h04;
  localparam logic [RegOffsetWidth-1:0] TimerCmpLoOffset  = 8'h08;
  localparam logic [RegOffsetWidth-1:0] TimerCmpHiOffset  = 8'h0C;

  // PWM period register
  // Duty register n sits at offset 4*n below this one
  localparam logic [RegOffsetWidth-1:0] PwmPeriodOffset = 8'h40;

  // Bus controller states
  typedef enum logic [1:0] {
    BusIdle,     // Ready to grant
    BusWaitInt,  // Internal or unmapped response due this cycle
    BusWaitRam   // Waiting on external memory
  } bus_state_e;

endpackage

//--- logic/bus_ctrl.sv
// Single host bus controller with fixed address decode
// Grants one access at a time and returns exactly one response per grant
`timescale 1ns/10ps

module bus_ctrl (
  input  logic                                   clk_sys_i,
  input  logic                                   rst_sys_ni,
  // Host port
  input  logic                                   host_req_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0]   host_addr_i,
  input  logic                                   host_we_i,
  input  logic [soc_bus_pkg::BusBeWidth-1:0]     host_be_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0]   host_wdata_i,
  output logic                                   host_gnt_o,
  output logic                                   host_rvalid_o,
  output logic [soc_bus_pkg::BusDataWidth-1:0]   host_rdata_o,
  output logic                                   host_err_o,
  // External RAM port
  output logic                                   mem_req_o,
  output logic                                   mem_we_o,
  output logic [soc_bus_pkg::BusBeWidth-1:0]     mem_be_o,
  output logic [soc_bus_pkg::BusDataWidth-1:0]   mem_addr_o,
  output logic [soc_bus_pkg::BusDataWidth-1:0]   mem_wdata_o,
  input  logic                                   mem_rvalid_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0]   mem_rdata_i,
  // Peripheral register port
  output logic                                   gpio_req_o,
  output logic                                   timer_req_o,
  output logic                                   pwm_req_o,
  output logic                                   reg_we_o,
  output logic [soc_bus_pkg::BusBeWidth-1:0]     reg_be_o,
  output logic [soc_bus_pkg::RegOffsetWidth-1:0] reg_offset_o,
  output logic [soc_bus_pkg::BusDataWidth-1:0]   reg_wdata_o,
  input  logic [soc_bus_pkg::BusDataWidth-1:0]   gpio_rdata_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0]   timer_rdata_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0]   pwm_rdata_i
);

  soc_bus_pkg::bus_state_e state_q;
  soc_bus_pkg::bus_state_e state_d;

  logic ram_sel;
  logic gpio_sel;
  logic timer_sel;
  logic pwm_sel;
  logic unmapped;
  logic grant;

  // Target of the access in flight
  logic gpio_q;
  logic timer_q;
  logic pwm_q;
  logic unmapped_q;
  logic we_q;

  logic [soc_bus_pkg::BusDataWidth-1:0] int_rdata;

  assign ram_sel   = (host_addr_i & soc_bus_pkg::RamMask) == soc_bus_pkg::RamStart;
  assign gpio_sel  = (host_addr_i & soc_bus_pkg::GpioMask) == soc_bus_pkg::GpioStart;
  assign timer_sel = (host_addr_i & soc_bus_pkg::TimerMask) == soc_bus_pkg::TimerStart;
  assign pwm_sel   = (host_addr_i & soc_bus_pkg::PwmMask) == soc_bus_pkg::PwmStart;
  assign unmapped  = ~(ram_sel | gpio_sel | timer_sel | pwm_sel);

  assign grant      = host_req_i && (state_q == soc_bus_pkg::BusIdle);
  assign host_gnt_o = grant;

  always_comb begin
    state_d = state_q;
    case (state_q)
      soc_bus_pkg::BusIdle: begin
        if (grant) begin
          state_d = ram_sel ? soc_bus_pkg::BusWaitRam : soc_bus_pkg::BusWaitInt;
        end
      end
      soc_bus_pkg::BusWaitInt: state_d = soc_bus_pkg::BusIdle;  // Always answered here
      soc_bus_pkg::BusWaitRam: begin
        if (mem_rvalid_i) begin
          state_d = soc_bus_pkg::BusIdle;
        end
      end
      default: state_d = soc_bus_pkg::BusIdle;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      state_q    <= soc_bus_pkg::BusIdle;
      gpio_q     <= 1'b0;
      timer_q    <= 1'b0;
      pwm_q      <= 1'b0;
      unmapped_q <= 1'b0;
      we_q       <= 1'b0;
    end else begin
      state_q <= state_d;
      if (grant) begin
        gpio_q     <= gpio_sel;
        timer_q    <= timer_sel;
        pwm_q      <= pwm_sel;
        unmapped_q <= unmapped;
        we_q       <= host_we_i;
      end
    end
  end

  // RAM request is a single pulse in the grant cycle
  assign mem_req_o   = grant & ram_sel;
  assign mem_we_o    = host_we_i;
  assign mem_be_o    = host_be_i;
  assign mem_addr_o  = host_addr_i;
  assign mem_wdata_o = host_wdata_i;

  assign gpio_req_o   = grant & gpio_sel;
  assign timer_req_o  = grant & timer_sel;
  assign pwm_req_o    = grant & pwm_sel;
  assign reg_we_o     = host_we_i;
  assign reg_be_o     = host_be_i;
  assign reg_offset_o = host_addr_i[soc_bus_pkg::RegOffsetWidth-1:0];
  assign reg_wdata_o  = host_wdata_i;

  // Unmapped accesses fall through to zero
  always_comb begin
    int_rdata = '0;
    if (gpio_q) begin
      int_rdata = gpio_rdata_i;
    end else if (timer_q) begin
      int_rdata = timer_rdata_i;
    end else if (pwm_q) begin
      int_rdata = pwm_rdata_i;
    end
  end

  assign host_rvalid_o = (state_q == soc_bus_pkg::BusWaitInt) ||
                         ((state_q == soc_bus_pkg::BusWaitRam) && mem_rvalid_i);
  assign host_err_o    = (state_q == soc_bus_pkg::BusWaitInt) && unmapped_q;

  always_comb begin
    host_rdata_o = '0;
    if (host_rvalid_o && !we_q) begin  // Writes answer with zero
      host_rdata_o = (state_q == soc_bus_pkg::BusWaitRam) ? mem_rdata_i : int_rdata;
    end
  end

endmodule

//--- logic/gpio_regs.sv
// GPIO block with a byte-writable output register and synchronized inputs
// Read data is registered and valid the cycle after the request
`timescale 1ns/10ps

module gpio_regs #(
  parameter int GpiWidth = 8,
  parameter int GpoWidth = 16
) (
  input  logic                                   clk_sys_i,
  input  logic                                   rst_sys_ni,
  input  logic                                   req_i,
  input  logic                                   we_i,
  input  logic [soc_bus_pkg::BusBeWidth-1:0]     be_i,
  input  logic [soc_bus_pkg::RegOffsetWidth-1:0] offset_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0]   wdata_i,
  output logic [soc_bus_pkg::BusDataWidth-1:0]   rdata_o,
  input  logic [GpiWidth-1:0]                    gp_i,
  output logic [GpoWidth-1:0]                    gp_o
);

  logic                wr_out;
  logic [GpiWidth-1:0] gpi_meta_q;  // First sync stage
  logic [GpiWidth-1:0] gpi_sync_q;

  assign wr_out = req_i && we_i && (offset_i == soc_bus_pkg::GpioOutOffset);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_o       <= '0;
      gpi_meta_q <= '0;
      gpi_sync_q <= '0;
    end else begin
      gpi_meta_q <= gp_i;
      gpi_sync_q <= gpi_meta_q;
      if (wr_out) begin
        for (int i = 0; i < GpoWidth; i++) begin
          if (be_i[i/8]) begin
            gp_o[i] <= wdata_i[i];
          end
        end
      end
    end
  end

  // Value before any write in the same cycle
  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_o <= '0;
      if (offset_i == soc_bus_pkg::GpioOutOffset) begin
        rdata_o[GpoWidth-1:0] <= gp_o;
      end else if (offset_i == soc_bus_pkg::GpioInOffset) begin
        rdata_o[GpiWidth-1:0] <= gpi_sync_q;
      end
    end
  end

endmodule

//--- logic/timer_regs.sv
// Machine timer with 64-bit mtime and mtimecmp accessed in 32-bit halves
// Interrupt level is high while mtime is at or past mtimecmp
`timescale 1ns/10ps

module timer_regs (
  input  logic                                   clk_sys_i,
  input  logic                                   rst_sys_ni,
  input  logic                                   req_i,
  input  logic                                   we_i,
  input  logic [soc_bus_pkg::BusBeWidth-1:0]     be_i,
  input  logic [soc_bus_pkg::RegOffsetWidth-1:0] offset_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0]   wdata_i,
  output logic [soc_bus_pkg::BusDataWidth-1:0]   rdata_o,
  output logic                                   timer_irq_o
);

  logic        wr_en;
  logic [63:0] mtime_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtimecmp_d;

  // Replace only the enabled bytes of one half
  function automatic logic [31:0] merge_be(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < soc_bus_pkg::BusBeWidth; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign wr_en = req_i && we_i;

  always_comb begin
    mtime_d    = mtime_q + 64'd1;  // Free running
    mtimecmp_d = mtimecmp_q;
    if (wr_en) begin
      case (offset_i)
        soc_bus_pkg::TimerTimeLoOffset: mtime_d[31:0]     = merge_be(mtime_q[31:0], wdata_i, be_i);
        soc_bus_pkg::TimerTimeHiOffset: mtime_d[63:32]    = merge_be(mtime_q[63:32], wdata_i, be_i);
        soc_bus_pkg::TimerCmpLoOffset:  mtimecmp_d[31:0]  = merge_be(mtimecmp_q[31:0], wdata_i, be_i);
        soc_bus_pkg::TimerCmpHiOffset:  mtimecmp_d[63:32] = merge_be(mtimecmp_q[63:32], wdata_i, be_i);
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;  // No interrupt until software sets a compare
      timer_irq_o <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      timer_irq_o <= mtime_q >= mtimecmp_q;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (offset_i)
        soc_bus_pkg::TimerTimeLoOffset: rdata_o <= mtime_q[31:0];
        soc_bus_pkg::TimerTimeHiOffset: rdata_o <= mtime_q[63:32];
        soc_bus_pkg::TimerCmpLoOffset:  rdata_o <= mtimecmp_q[31:0];
        soc_bus_pkg::TimerCmpHiOffset:  rdata_o <= mtimecmp_q[63:32];
        default:                        rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- logic/pwm_gen.sv
// PWM bank sharing one counter that wraps at the period register
// Channel n is high while the counter is below its duty value
`timescale 1ns/10ps

module pwm_gen #(
  parameter int PwmWidth   = 4,
  parameter int PwmCtrSize = 8
) (
  input  logic                                   clk_sys_i,
  input  logic                                   rst_sys_ni,
  input  logic                                   req_i,
  input  logic                                   we_i,
  input  logic [soc_bus_pkg::BusBeWidth-1:0]     be_i,
  input  logic [soc_bus_pkg::RegOffsetWidth-1:0] offset_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0]   wdata_i,
  output logic [soc_bus_pkg::BusDataWidth-1:0]   rdata_o,
  output logic [PwmWidth-1:0]                    pwm_o
);

  logic                  wr_en;
  logic [PwmCtrSize-1:0] ctr_q;
  logic [PwmCtrSize-1:0] period_q;
  logic [PwmCtrSize-1:0] duty_q [PwmWidth];

  assign wr_en = req_i && we_i;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      ctr_q    <= '0;
      period_q <= '0;
      pwm_o    <= '0;
      for (int n = 0; n < PwmWidth; n++) begin
        duty_q[n] <= '0;
      end
    end else begin
      ctr_q <= (ctr_q == period_q) ? '0 : ctr_q + 1'b1;  // Counts 0 to period
      for (int n = 0; n < PwmWidth; n++) begin
        pwm_o[n] <= ctr_q < duty_q[n];
      end
      if (wr_en) begin
        for (int i = 0; i < PwmCtrSize; i++) begin
          if (be_i[i/8] && offset_i == soc_bus_pkg::PwmPeriodOffset) begin
            period_q[i] <= wdata_i[i];
          end
          for (int n = 0; n < PwmWidth; n++) begin
            if (be_i[i/8] && int'(offset_i) == 4 * n) begin
              duty_q[n][i] <= wdata_i[i];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_o <= '0;
      if (offset_i == soc_bus_pkg::PwmPeriodOffset) begin
        rdata_o[PwmCtrSize-1:0] <= period_q;
      end
      for (int n = 0; n < PwmWidth; n++) begin
        if (int'(offset_i) == 4 * n) begin
          rdata_o[PwmCtrSize-1:0] <= duty_q[n];
        end
      end
    end
  end

endmodule

//--- logic/demo_soc_top.sv
// Top level of the demo SoC peripheral side
// Connects the host port to the bus controller, the RAM port and the peripherals
`timescale 1ns/10ps

module demo_soc_top #(
  parameter int GpiWidth   = 8,
  parameter int GpoWidth   = 16,
  parameter int PwmWidth   = 4,
  parameter int PwmCtrSize = 8
) (
  input  logic                                 clk_sys_i,
  input  logic                                 rst_sys_ni,
  // Host port
  input  logic                                 host_req_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0] host_addr_i,
  input  logic                                 host_we_i,
  input  logic [soc_bus_pkg::BusBeWidth-1:0]   host_be_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0] host_wdata_i,
  output logic                                 host_gnt_o,
  output logic                                 host_rvalid_o,
  output logic [soc_bus_pkg::BusDataWidth-1:0] host_rdata_o,
  output logic                                 host_err_o,
  // External RAM
  output logic                                 mem_req_o,
  output logic                                 mem_we_o,
  output logic [soc_bus_pkg::BusBeWidth-1:0]   mem_be_o,
  output logic [soc_bus_pkg::BusDataWidth-1:0] mem_addr_o,
  output logic [soc_bus_pkg::BusDataWidth-1:0] mem_wdata_o,
  input  logic                                 mem_rvalid_i,
  input  logic [soc_bus_pkg::BusDataWidth-1:0] mem_rdata_i,
  // Pins and interrupt
  input  logic [GpiWidth-1:0]                  gp_i,
  output logic [GpoWidth-1:0]                  gp_o,
  output logic [PwmWidth-1:0]                  pwm_o,
  output logic                                 timer_irq_o
);

  logic                                   gpio_req;
  logic                                   timer_req;
  logic                                   pwm_req;
  logic                                   reg_we;
  logic [soc_bus_pkg::BusBeWidth-1:0]     reg_be;
  logic [soc_bus_pkg::RegOffsetWidth-1:0] reg_offset;
  logic [soc_bus_pkg::BusDataWidth-1:0]   reg_wdata;
  logic [soc_bus_pkg::BusDataWidth-1:0]   gpio_rdata;
  logic [soc_bus_pkg::BusDataWidth-1:0]   timer_rdata;
  logic [soc_bus_pkg::BusDataWidth-1:0]   pwm_rdata;

  bus_ctrl bus_ctrl_inst (
    .clk_sys_i     (clk_sys_i),
    .rst_sys_ni    (rst_sys_ni),
    .host_req_i    (host_req_i),
    .host_addr_i   (host_addr_i),
    .host_we_i     (host_we_i),
    .host_be_i     (host_be_i),
    .host_wdata_i  (host_wdata_i),
    .host_gnt_o    (host_gnt_o),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o),
    .host_err_o    (host_err_o),
    .mem_req_o     (mem_req_o),
    .mem_we_o      (mem_we_o),
    .mem_be_o      (mem_be_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .gpio_req_o    (gpio_req),
    .timer_req_o   (timer_req),
    .pwm_req_o     (pwm_req),
    .reg_we_o      (reg_we),
    .reg_be_o      (reg_be),
    .reg_offset_o  (reg_offset),
    .reg_wdata_o   (reg_wdata),
    .gpio_rdata_i  (gpio_rdata),
    .timer_rdata_i (timer_rdata),
    .pwm_rdata_i   (pwm_rdata)
  );

  gpio_regs #(
    .GpiWidth (GpiWidth),
    .GpoWidth (GpoWidth)
  ) gpio_regs_inst (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (gpio_req),
    .we_i       (reg_we),
    .be_i       (reg_be),
    .offset_i   (reg_offset),
    .wdata_i    (reg_wdata),
    .rdata_o    (gpio_rdata),
    .gp_i       (gp_i),
    .gp_o       (gp_o)
  );

  timer_regs timer_regs_inst (
    .clk_sys_i   (clk_sys_i),
    .rst_sys_ni  (rst_sys_ni),
    .req_i       (timer_req),
    .we_i        (reg_we),
    .be_i        (reg_be),
    .offset_i    (reg_offset),
    .wdata_i     (reg_wdata),
    .rdata_o     (timer_rdata),
    .timer_irq_o (timer_irq_o)
  );

  pwm_gen #(
    .PwmWidth   (PwmWidth),
    .PwmCtrSize (PwmCtrSize)
  ) pwm_gen_inst (
    .clk_sys_i  (clk_sys_i),
    .rst_sys_ni (rst_sys_ni),
    .req_i      (pwm_req),
    .we_i       (reg_we),
    .be_i       (reg_be),
    .offset_i   (reg_offset),
    .wdata_i    (reg_wdata),
    .rdata_o    (pwm_rdata),
    .pwm_o      (pwm_o)
  );

endmodule

//--- testbench/demo_soc_properties.sv
// Host bus protocol checks for the bus controller
// Attached to every bus_ctrl instance by the bind at the end of this file
`timescale 1ns/10ps

module demo_soc_properties (
  input logic clk_sys_i,
  input logic rst_sys_ni,
  input logic host_gnt_i,
  input logic host_rvalid_i,
  input logic host_err_i,
  input logic mem_req_i
);

  logic pending_q;  // Granted, response not yet seen
  int   gnt_fails = 0;
  int   timing_fails = 0;
  int   err_fails = 0;
  int   reset_fails = 0;
  int   fail_count;

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      pending_q <= 1'b0;
    end else if (host_gnt_i) begin
      pending_q <= 1'b1;
    end else if (host_rvalid_i) begin
      pending_q <= 1'b0;
    end
  end

  assign fail_count = gnt_fails + timing_fails + err_fails + reset_fails;

  no_gnt_while_pending: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
      pending_q |-> !host_gnt_i)
    else begin
      $error("Grant issued while a response was still pending");
      gnt_fails++;
    end

  // Anything not going to RAM answers on the next cycle
  int_resp_next_cycle: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
      host_gnt_i && !mem_req_i |=> host_rvalid_i)
    else begin
      $error("Internal or unmapped access not answered one cycle after grant");
      timing_fails++;
    end

  err_with_rvalid: assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
      host_err_i |-> host_rvalid_i)
    else begin
      $error("Error flag raised without a response");
      err_fails++;
    end

  quiet_in_reset: assert property (@(posedge clk_sys_i)
      !rst_sys_ni |-> !host_rvalid_i && !mem_req_i)
    else begin
      $error("Response or RAM request seen during reset");
      reset_fails++;
    end

endmodule

bind bus_ctrl demo_soc_properties props_inst (
  .clk_sys_i     (clk_sys_i),
  .rst_sys_ni    (rst_sys_ni),
  .host_gnt_i    (host_gnt_o),
  .host_rvalid_i (host_rvalid_o),
  .host_err_i    (host_err_o),
  .mem_req_i     (mem_req_o)
);

//--- testbench/tb_demo_soc.sv
// Testbench for the demo SoC peripheral side
// Drives the host port, models the external RAM and checks every response
`timescale 1ns/10ps

module tb_demo_soc;

  localparam int ClkPeriod     = 40;
  localparam int SampleDelay   = ClkPeriod / 4;  // Outputs settled, next edge far away
  localparam int TimeoutCycles = 4000;           // All five tests need under 600 cycles
  localparam int RamWords      = 256;
  localparam int PwmPeriod     = 9;

  localparam logic [31:0] RamBase   = 32'h0010_0000;
  localparam logic [31:0] GpioBase  = 32'h8000_0000;
  localparam logic [31:0] TimerBase = 32'h8000_2000;
  localparam logic [31:0] PwmBase   = 32'h8000_3000;

  logic        clk_sys;
  logic        rst_sys_n;
  logic        host_req;
  logic [31:0] host_addr;
  logic        host_we;
  logic [3:0]  host_be;
  logic [31:0] host_wdata;
  logic        host_gnt;
  logic        host_rvalid;
  logic [31:0] host_rdata;
  logic        host_err;
  logic        mem_req;
  logic        mem_we;
  logic [3:0]  mem_be;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_rvalid;
  logic [31:0] mem_rdata;
  logic [7:0]  gp_in;
  logic [15:0] gp_out;
  logic [3:0]  pwm_out;
  logic        timer_irq;

  int          seed = 32'h3908;
  int          test_errors;
  int          total_errors;
  int          tests_done;
  int          cycles;
  int          mem_req_count;
  int          ram_wait;
  logic [31:0] ram_rdata;
  logic [31:0] ram_mem [RamWords];

  demo_soc_top #(
    .GpiWidth   (8),
    .GpoWidth   (16),
    .PwmWidth   (4),
    .PwmCtrSize (8)
  ) demo_soc_top_inst (
    .clk_sys_i     (clk_sys),
    .rst_sys_ni    (rst_sys_n),
    .host_req_i    (host_req),
    .host_addr_i   (host_addr),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .host_err_o    (host_err),
    .mem_req_o     (mem_req),
    .mem_we_o      (mem_we),
    .mem_be_o      (mem_be),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_rvalid_i  (mem_rvalid),
    .mem_rdata_i   (mem_rdata),
    .gp_i          (gp_in),
    .gp_o          (gp_out),
    .pwm_o         (pwm_out),
    .timer_irq_o   (timer_irq)
  );

  initial begin
    clk_sys = 1'b0;
    forever #(ClkPeriod / 2) clk_sys = ~clk_sys;
  end

  // External RAM, answers each request after 1 to 4 cycles
  initial begin
    mem_rvalid    = 1'b0;
    mem_rdata     = '0;
    ram_wait      = 0;
    mem_req_count = 0;
    forever begin
      @(negedge clk_sys);
      mem_rvalid = 1'b0;
      mem_rdata  = '0;
      if (ram_wait > 0) begin
        ram_wait--;
        if (ram_wait == 0) begin
          mem_rvalid = 1'b1;
          mem_rdata  = ram_rdata;
        end
      end
      #SampleDelay;
      if (mem_req) begin
        mem_req_count++;
        for (int b = 0; b < 4; b++) begin
          if (mem_we && mem_be[b]) begin
            ram_mem[mem_addr[9:2]][8*b +: 8] = mem_wdata[8*b +: 8];
          end
        end
        ram_rdata = mem_we ? 32'h0 : ram_mem[mem_addr[9:2]];
        ram_wait  = 1 + ($unsigned($random(seed)) % 4);
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_sys);
      cycles++;
    end
    $display("Timeout: run stopped after %0d cycles without finishing", cycles);
    $display("Testbench failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: %0d failed checks", name, test_errors);
    end
    total_errors += test_errors;
    test_errors = 0;
    tests_done++;
  endtask

  // One access, request held until granted
  task automatic bus_access(input logic [31:0] addr, input logic we, input logic [3:0] be,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk_sys);
    host_req   = 1'b1;
    host_addr  = addr;
    host_we    = we;
    host_be    = be;
    host_wdata = wdata;
    #SampleDelay;
    while (!host_gnt) begin
      @(negedge clk_sys);
      #SampleDelay;
    end
    @(negedge clk_sys);
    host_req = 1'b0;
    #SampleDelay;
    while (!host_rvalid) begin
      @(negedge clk_sys);
      #SampleDelay;
    end
    rdata = host_rdata;
    err   = host_err;
  endtask

  // Two RAM reads with the request kept high across the first wait
  task automatic held_reads(input logic [31:0] addr0, input logic [31:0] addr1,
                            output logic [31:0] data0, output logic [31:0] data1);
    int grants;
    bit resp0_seen;
    grants     = 0;
    resp0_seen = 1'b0;
    @(negedge clk_sys);
    host_req  = 1'b1;
    host_addr = addr0;
    host_we   = 1'b0;
    host_be   = 4'hF;
    while (grants < 2) begin
      #SampleDelay;
      if (host_rvalid) begin
        data0      = host_rdata;
        resp0_seen = 1'b1;
      end
      if (host_gnt) begin
        grants++;
        if (grants == 2) begin
          assert (resp0_seen) else begin
            $display("Second RAM request was granted before the first response");
            test_errors++;
          end
        end
      end
      @(negedge clk_sys);
      if (grants == 1) host_addr = addr1;
    end
    host_req = 1'b0;
    #SampleDelay;
    while (!host_rvalid) begin
      @(negedge clk_sys);
      #SampleDelay;
    end
    data1 = host_rdata;
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [31:0] t0;
    logic [31:0] t1;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] exp_data [8];
    int          duty [4];
    int          high_cnt [4];
    int          wait_cnt;
    int          start_reqs;
    int          prop_fails;

    rst_sys_n    = 1'b0;
    host_req     = 1'b0;
    host_addr    = '0;
    host_we      = 1'b0;
    host_be      = '0;
    host_wdata   = '0;
    gp_in        = '0;
    test_errors  = 0;
    total_errors = 0;
    tests_done   = 0;
    duty         = '{0, 4, 9, 0};
    repeat (8) @(posedge clk_sys);
    check_value("timer_irq_o", 32'h0, 32'(timer_irq));
    @(negedge clk_sys);
    rst_sys_n = 1'b1;

    // Only byte 0 of the first write and byte 1 of the second land
    bus_access(GpioBase, 1'b1, 4'b0001, 32'hA5A5_A5C3, rdata, err);
    bus_access(GpioBase, 1'b1, 4'b0010, 32'hFFFF_1234, rdata, err);
    bus_access(GpioBase, 1'b0, 4'hF, '0, rdata, err);
    check_value("host_rdata_o", 32'h0000_12C3, rdata);
    check_value("host_err_o", 32'h0, 32'(err));
    check_value("gp_o", 32'h0000_12C3, 32'(gp_out));
    @(negedge clk_sys);
    gp_in = 8'h5A;
    repeat (3) @(negedge clk_sys);
    bus_access(GpioBase + 32'h4, 1'b0, 4'hF, '0, rdata, err);
    check_value("host_rdata_o", 32'h0000_005A, rdata);
    finish_test("gpio");

    start_reqs = mem_req_count;
    bus_access(32'h4000_0000, 1'b0, 4'hF, '0, rdata, err);
    check_value("host_err_o", 32'h1, 32'(err));
    check_value("host_rdata_o", 32'h0, rdata);
    bus_access(32'h8000_1000, 1'b1, 4'hF, 32'hDEAD_BEEF, rdata, err);  // Hole between GPIO and timer
    check_value("host_err_o", 32'h1, 32'(err));
    check_value("mem_req_o pulses", 32'h0, 32'(mem_req_count - start_reqs));
    finish_test("unmapped");

    for (int i = 0; i < 8; i++) begin
      exp_data[i] = $random(seed);
      bus_access(RamBase + 32'(i * 4), 1'b1, 4'hF, exp_data[i], rdata, err);
    end
    for (int i = 0; i < 8; i++) begin
      bus_access(RamBase + 32'(i * 4), 1'b0, 4'hF, '0, rdata, err);
      check_value("host_rdata_o", exp_data[i], rdata);
    end
    held_reads(RamBase + 32'h4, RamBase + 32'h8, d0, d1);
    check_value("host_rdata_o", exp_data[1], d0);
    check_value("host_rdata_o", exp_data[2], d1);
    finish_test("ram");

    check_value("timer_irq_o", 32'h0, 32'(timer_irq));
    bus_access(TimerBase, 1'b0, 4'hF, '0, t0, err);
    bus_access(TimerBase, 1'b0, 4'hF, '0, t1, err);
    assert (t1 > t0) else begin
      $display("CHECK FAILED at %0t: mtime expected above %h, got %h", $time, t0, t1);
      test_errors++;
    end
    // Low half first so the compare never dips below mtime on the way
    bus_access(TimerBase + 32'h8, 1'b1, 4'hF, t1 + 32'd60, rdata, err);
    bus_access(TimerBase + 32'hC, 1'b1, 4'hF, 32'h0, rdata, err);
    wait_cnt = 0;
    while (!timer_irq && wait_cnt < 200) begin
      @(negedge clk_sys);
      #SampleDelay;
      wait_cnt++;
    end
    assert (timer_irq) else begin
      $display("Timer interrupt never rose after mtimecmp was set");
      test_errors++;
    end
    repeat (20) begin
      @(negedge clk_sys);
      #SampleDelay;
      check_value("timer_irq_o", 32'h1, 32'(timer_irq));
    end
    bus_access(TimerBase + 32'hC, 1'b1, 4'hF, 32'hFFFF_FFFF, rdata, err);
    bus_access(TimerBase + 32'h8, 1'b1, 4'hF, 32'hFFFF_FFFF, rdata, err);
    repeat (2) @(negedge clk_sys);
    #SampleDelay;
    check_value("timer_irq_o", 32'h0, 32'(timer_irq));
    finish_test("timer");

    bus_access(PwmBase + 32'h40, 1'b1, 4'b0001, 32'(PwmPeriod), rdata, err);
    for (int n = 0; n < 4; n++) begin
      bus_access(PwmBase + 32'(4 * n), 1'b1, 4'b0001, 32'(duty[n]), rdata, err);
    end
    bus_access(PwmBase + 32'h40, 1'b0, 4'hF, '0, rdata, err);
    check_value("host_rdata_o", 32'(PwmPeriod), rdata);
    bus_access(PwmBase + 32'h4, 1'b0, 4'hF, '0, rdata, err);
    check_value("host_rdata_o", 32'(duty[1]), rdata);
    for (int n = 0; n < 4; n++) high_cnt[n] = 0;
    repeat (2 * (PwmPeriod + 1)) begin  // Two full periods
      @(negedge clk_sys);
      #SampleDelay;
      for (int n = 0; n < 4; n++) begin
        if (pwm_out[n]) high_cnt[n]++;
      end
    end
    for (int n = 0; n < 4; n++) begin
      check_value($sformatf("pwm_o[%0d] high cycles", n), 32'(2 * duty[n]), 32'(high_cnt[n]));
    end
    finish_test("pwm");

    prop_fails = demo_soc_top_inst.bus_ctrl_inst.props_inst.fail_count;
    $display("Summary: %0d tests, %0d failed checks, %0d protocol assertion failures",
             tests_done, total_errors, prop_fails);
    if (total_errors == 0 && prop_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- filelist.f
logic/soc_bus_pkg.sv
logic/bus_ctrl.sv
logic/gpio_regs.sv
logic/timer_regs.sv
logic/pwm_gen.sv
logic/demo_soc_top.sv
testbench/demo_soc_properties.sv
testbench/tb_demo_soc.sv

//--- Makefile
# Verilator build and run for the demo SoC testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = tb_demo_soc
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Testbench passed
RUN_FLAGS = +verilator+error+limit+1000

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(RUN_FLAGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
